// ==== design/ctl_pkg.sv ====
`default_nettype none

package ctl_pkg;

	// bus side
	typedef logic [19:0] addr_t;	// byte address, bits 19:4 decoded

	localparam int DATA_WIDTH = 32;

	// register offsets, compared against addr[19:4]
	localparam logic [15:0] REG_IN_1   = 16'h1300;	// connect command
	localparam logic [15:0] REG_IN_2   = 16'h1310;	// substitute command
	localparam logic [15:0] REG_C_IMSH = 16'h1330;	// commutator
	localparam logic [15:0] REG_R_ERR  = 16'hF000;	// error flags, clear on read
	localparam logic [15:0] REG_R_TEST = 16'hFFF0;	// scratch

	localparam int C_IMSH_WIDTH = 9;
	localparam int ERR_WIDTH    = 8;
	localparam int ERR_MODE_BIT = 7;	// mode not one-hot
	localparam int ERR_ADDR_BIT = 0;	// unmapped access
	localparam int BUSY_BIT     = 17;	// busy flag in IN_1 readback

	// relay command modes, one-hot
	typedef enum logic [3:0] {
		MODE_FULL    = 4'b0001,
		MODE_GROUP   = 4'b0010,
		MODE_ADDR    = 4'b0100,
		MODE_SECTION = 4'b1000
	} relay_mode_e;

	// bank groups
	typedef enum logic [2:0] {
		GRP_A      = 3'd1,
		GRP_B      = 3'd2,
		GRP_C      = 3'd3,
		GRP_D_LOW  = 3'd4,
		GRP_D_HIGH = 3'd5,
		GRP_CNTRL  = 3'd6
	} relay_group_e;

	// layout of IN_1 / IN_2
	typedef struct packed {
		logic [4:0] index;	// relay position in bank
		logic       enable;	// channel enable
		logic [2:0] group;
		logic [2:0] spare;
		logic       on;	// 1 closes, 0 opens
		logic [3:0] mode;
	} relay_cmd_t;

	localparam int CMD_WIDTH = $bits(relay_cmd_t);

	// bank widths
	localparam int BANK_WIDTH   = 32;
	localparam int D_HIGH_WIDTH = 24;
	localparam int CNTRL_WIDTH  = 4;

	localparam int NUM_BANKS = 6;	// a, b, c, d-low, d-high, control

endpackage

`default_nettype wire

// ==== design/relay_cmd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one command channel, register block to relay banks
interface relay_cmd_if;

	logic       apply;	// single cycle, after a register write
	logic [3:0] mode;
	logic       on;
	logic [2:0] group;
	logic [4:0] index;
	logic       enable;	// level, follows register bit 11

	modport src (
		output apply,
		output mode,
		output on,
		output group,
		output index,
		output enable
	);

	modport dst (
		input apply,
		input mode,
		input on,
		input group,
		input index,
		input enable
	);

endinterface

`default_nettype wire

// ==== design/bus_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_regs import ctl_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_,
	input  logic                  bus_valid,
	input  logic                  bus_wr,
	input  addr_t                 bus_addr,
	input  logic [DATA_WIDTH-1:0] bus_wdata,
	input  logic                  busy,
	output logic [DATA_WIDTH-1:0] bus_rdata,
	output logic                  bus_rvalid,
	output logic                  co_en,
	output logic [1:0]            co_a,
	output logic [1:0]            co_b,
	output logic [1:0]            co_c,
	output logic [1:0]            co_d,
	relay_cmd_if.src              sel_cmd,
	relay_cmd_if.src              sus_cmd
);

	logic [15:0]             offset;
	logic                    wr_stb;
	logic                    rd_stb;
	logic                    hit_in_1;
	logic                    hit_in_2;
	logic                    hit_c_imsh;
	logic                    hit_r_err;
	logic                    hit_r_test;
	logic                    hit_any;
	relay_cmd_t              wr_cmd;
	logic                    mode_bad;
	relay_cmd_t              in_1;
	relay_cmd_t              in_2;
	logic [C_IMSH_WIDTH-1:0] c_imsh;
	logic [DATA_WIDTH-1:0]   r_test;
	logic [ERR_WIDTH-1:0]    r_err;
	logic                    sel_apply;
	logic                    sus_apply;
	logic [DATA_WIDTH-1:0]   rd_mux;

	assign offset = bus_addr[19:4];
	assign wr_stb = bus_valid && bus_wr;
	assign rd_stb = bus_valid && !bus_wr;

	assign hit_in_1   = (offset == REG_IN_1);
	assign hit_in_2   = (offset == REG_IN_2);
	assign hit_c_imsh = (offset == REG_C_IMSH);
	assign hit_r_err  = (offset == REG_R_ERR);
	assign hit_r_test = (offset == REG_R_TEST);
	assign hit_any    = hit_in_1 || hit_in_2 || hit_c_imsh || hit_r_err || hit_r_test;

	// incoming command, checked before it is stored
	assign wr_cmd   = bus_wdata[CMD_WIDTH-1:0];
	assign mode_bad = !(wr_cmd.mode inside {MODE_FULL, MODE_GROUP, MODE_ADDR, MODE_SECTION});

	always_ff @(posedge clk)
	begin
		if (!rst_)
		begin
			in_1   <= '0;
			in_2   <= '0;
			c_imsh <= '0;
		end
		else if (wr_stb)
		begin
			if (hit_in_1)
				in_1 <= wr_cmd;
			if (hit_in_2)
				in_2 <= wr_cmd;
			if (hit_c_imsh)
				c_imsh <= bus_wdata[C_IMSH_WIDTH-1:0];
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_stb && hit_r_test)
			r_test <= bus_wdata;
	end

	// one apply per write, the next cycle
	always_ff @(posedge clk)
	begin
		if (!rst_)
		begin
			sel_apply <= 1'b0;
			sus_apply <= 1'b0;
		end
		else
		begin
			sel_apply <= wr_stb && hit_in_1;
			sus_apply <= wr_stb && hit_in_2;
		end
	end

	assign sel_cmd.apply  = sel_apply;
	assign sel_cmd.mode   = in_1.mode;
	assign sel_cmd.on     = in_1.on;
	assign sel_cmd.group  = in_1.group;
	assign sel_cmd.index  = in_1.index;
	assign sel_cmd.enable = in_1.enable;

	assign sus_cmd.apply  = sus_apply;
	assign sus_cmd.mode   = in_2.mode;
	assign sus_cmd.on     = in_2.on;
	assign sus_cmd.group  = in_2.group;
	assign sus_cmd.index  = in_2.index;
	assign sus_cmd.enable = in_2.enable;

	// error flags are sticky until R_ERR is read
	always_ff @(posedge clk)
	begin
		if (!rst_)
			r_err <= '0;
		else if (rd_stb && hit_r_err)
			r_err <= '0;	// read and clear
		else if (bus_valid && !hit_any)
			r_err[ERR_ADDR_BIT] <= 1'b1;
		else if (wr_stb && (hit_in_1 || hit_in_2) && mode_bad)
			r_err[ERR_MODE_BIT] <= 1'b1;
	end

	always_comb
	begin
		rd_mux = '0;
		case (offset)
			REG_IN_1:
			begin
				rd_mux[CMD_WIDTH-1:0] = in_1;
				rd_mux[BUSY_BIT]      = busy;
			end
			REG_IN_2:   rd_mux[CMD_WIDTH-1:0]    = in_2;
			REG_C_IMSH: rd_mux[C_IMSH_WIDTH-1:0] = c_imsh;
			REG_R_ERR:  rd_mux[ERR_WIDTH-1:0]    = r_err;
			REG_R_TEST: rd_mux                   = r_test;
			default:    rd_mux                   = '0;	// unmapped reads zero
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_)
		begin
			bus_rvalid <= 1'b0;
			bus_rdata  <= '0;
		end
		else
		begin
			bus_rvalid <= rd_stb;
			bus_rdata  <= rd_stb ? rd_mux : '0;	// bus idles at zero
		end
	end

	// commutator fields, enable is active low in the register
	assign co_en = !c_imsh[8];
	assign co_a  = c_imsh[7:6];
	assign co_b  = c_imsh[5:4];
	assign co_c  = c_imsh[3:2];
	assign co_d  = c_imsh[1:0];

	// banks rely on seeing at most one command per cycle
	apply_exclusive: assert property (@(posedge clk) disable iff (!rst_)
		!(sel_cmd.apply && sus_cmd.apply));

endmodule

`default_nettype wire

// ==== design/relay_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module relay_bank import ctl_pkg::*; #(
	parameter int           WIDTH = BANK_WIDTH,
	parameter relay_group_e GROUP = GRP_A
) (
	input  logic             clk,
	input  logic             rst_,
	relay_cmd_if.dst         sel_cmd,
	relay_cmd_if.dst         sus_cmd,
	output logic [WIDTH-1:0] sel,
	output logic [WIDTH-1:0] sus,
	output logic             any_on
);

	localparam int  IDX_W    = $clog2(WIDTH);
	localparam bit  IS_CNTRL = (GROUP == GRP_CNTRL);

	logic [WIDTH-1:0] sel_mask;
	logic [WIDTH-1:0] sus_mask;

	// which bits of this bank a command addresses
	function automatic logic [WIDTH-1:0] cmd_mask(
		input logic [3:0] mode,
		input logic [2:0] grp,
		input logic [4:0] idx
	);
		logic [WIDTH-1:0] one_bit;
		logic [WIDTH-1:0] mask;
		one_bit = '0;
		mask    = '0;
		if (int'(idx) < WIDTH)
			one_bit[idx[IDX_W-1:0]] = 1'b1;	// out of range selects nothing
		case (mode)
			MODE_FULL:
				mask = '1;
			MODE_GROUP:
				if (grp == GROUP)
					mask = '1;
			MODE_ADDR:
				if (grp == GROUP)
					mask = one_bit;
			MODE_SECTION:
				if (GROUP inside {GRP_A, GRP_B, GRP_C, GRP_D_LOW})
					mask = one_bit;
			default:
				mask = '0;	// bad mode, flagged in R_ERR
		endcase
		return mask;
	endfunction

	assign sel_mask = cmd_mask(sel_cmd.mode, sel_cmd.group, sel_cmd.index);
	assign sus_mask = IS_CNTRL ? '0 : cmd_mask(sus_cmd.mode, sus_cmd.group, sus_cmd.index);

	always_ff @(posedge clk)
	begin
		if (!rst_ || (!sel_cmd.enable && !sus_cmd.enable))
		begin
			sel <= '0;	// both channels off drops every relay
			sus <= '0;
		end
		else if (sel_cmd.apply)
		begin
			if (sel_cmd.on)
			begin
				sel <= sel | sel_mask;
				sus <= sus & ~sel_mask;	// sensor takes over from DAC
			end
			else
				sel <= sel & ~sel_mask;
		end
		else if (sus_cmd.apply)
		begin
			if (sus_cmd.on)
			begin
				sus <= sus | sus_mask;
				sel <= sel & ~sus_mask;	// DAC takes over from sensor
			end
			else
				sus <= sus & ~sus_mask;
		end
	end

	assign any_on = |sel || |sus;

	// a relay point is never driven by sensor and DAC together
	sel_sus_exclusive: assert property (@(posedge clk) disable iff (!rst_)
		(sel & sus) == '0);

endmodule

`default_nettype wire

// ==== design/settle_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module settle_timer import ctl_pkg::*; #(
	parameter int SETTLE_CYCLES = 25
) (
	input  logic                 clk,
	input  logic                 rst_,
	input  logic [NUM_BANKS-1:0] any_on,
	output logic                 busy
);

	localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

	logic             active;
	logic [CNT_W-1:0] count;

	assign active = |any_on;

	// reloads while relays are on and drains once all are open
	always_ff @(posedge clk)
	begin
		if (!rst_)
			count <= '0;
		else if (active)
			count <= CNT_W'(SETTLE_CYCLES);
		else if (count != '0)
			count <= count - 1'b1;
	end

	assign busy = active || (count != '0);

	// busy covers every cycle with a closed relay and the settle time after it
	busy_covers_on: assert property (@(posedge clk) disable iff (!rst_)
		active |-> busy [*SETTLE_CYCLES + 1]);

	// busy ends once every relay has stayed open for the settle time
	busy_ends: assert property (@(posedge clk) disable iff (!rst_)
		(!active) [*SETTLE_CYCLES + 1] |-> !busy);

endmodule

`default_nettype wire

// ==== design/relay_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module relay_ctrl_top import ctl_pkg::*; #(
	parameter int SETTLE_CYCLES = 25
) (
	input  logic                               clk,
	input  logic                               rst_,
	input  logic                               bus_valid,
	input  logic                               bus_wr,
	input  addr_t                              bus_addr,
	input  logic [DATA_WIDTH-1:0]              bus_wdata,
	output logic [DATA_WIDTH-1:0]              bus_rdata,
	output logic                               bus_rvalid,
	output logic [BANK_WIDTH-1:0]              a_sel,
	output logic [BANK_WIDTH-1:0]              b_sel,
	output logic [BANK_WIDTH-1:0]              c_sel,
	output logic [BANK_WIDTH+D_HIGH_WIDTH-1:0] d_sel,
	output logic [CNTRL_WIDTH-1:0]             cntrl_e,
	output logic [BANK_WIDTH-1:0]              a_sus,
	output logic [BANK_WIDTH-1:0]              b_sus,
	output logic [BANK_WIDTH-1:0]              c_sus,
	output logic [BANK_WIDTH+D_HIGH_WIDTH-1:0] d_sus,
	output logic                               co_en,
	output logic [1:0]                         co_a,
	output logic [1:0]                         co_b,
	output logic [1:0]                         co_c,
	output logic [1:0]                         co_d,
	output logic                               busy
);

	logic [NUM_BANKS-1:0] any_on;	// one flag per bank

	relay_cmd_if sel_cmd ();	// from IN_1
	relay_cmd_if sus_cmd ();	// from IN_2

	bus_regs u_regs (
		.clk        (clk),
		.rst_       (rst_),
		.bus_valid  (bus_valid),
		.bus_wr     (bus_wr),
		.bus_addr   (bus_addr),
		.bus_wdata  (bus_wdata),
		.busy       (busy),
		.bus_rdata  (bus_rdata),
		.bus_rvalid (bus_rvalid),
		.co_en      (co_en),
		.co_a       (co_a),
		.co_b       (co_b),
		.co_c       (co_c),
		.co_d       (co_d),
		.sel_cmd    (sel_cmd.src),
		.sus_cmd    (sus_cmd.src)
	);

	relay_bank #(.WIDTH(BANK_WIDTH), .GROUP(GRP_A)) u_bank_a (
		.clk (clk), .rst_ (rst_), .sel_cmd (sel_cmd.dst), .sus_cmd (sus_cmd.dst),
		.sel (a_sel), .sus (a_sus), .any_on (any_on[0])
	);

	relay_bank #(.WIDTH(BANK_WIDTH), .GROUP(GRP_B)) u_bank_b (
		.clk (clk), .rst_ (rst_), .sel_cmd (sel_cmd.dst), .sus_cmd (sus_cmd.dst),
		.sel (b_sel), .sus (b_sus), .any_on (any_on[1])
	);

	relay_bank #(.WIDTH(BANK_WIDTH), .GROUP(GRP_C)) u_bank_c (
		.clk (clk), .rst_ (rst_), .sel_cmd (sel_cmd.dst), .sus_cmd (sus_cmd.dst),
		.sel (c_sel), .sus (c_sus), .any_on (any_on[2])
	);

	// d bank is split, high part sits above low part on the ports
	relay_bank #(.WIDTH(BANK_WIDTH), .GROUP(GRP_D_LOW)) u_bank_d_low (
		.clk (clk), .rst_ (rst_), .sel_cmd (sel_cmd.dst), .sus_cmd (sus_cmd.dst),
		.sel (d_sel[BANK_WIDTH-1:0]), .sus (d_sus[BANK_WIDTH-1:0]), .any_on (any_on[3])
	);

	relay_bank #(.WIDTH(D_HIGH_WIDTH), .GROUP(GRP_D_HIGH)) u_bank_d_high (
		.clk (clk), .rst_ (rst_), .sel_cmd (sel_cmd.dst), .sus_cmd (sus_cmd.dst),
		.sel (d_sel[BANK_WIDTH +: D_HIGH_WIDTH]), .sus (d_sus[BANK_WIDTH +: D_HIGH_WIDTH]),
		.any_on (any_on[4])
	);

	// control enables have no DAC side
	relay_bank #(.WIDTH(CNTRL_WIDTH), .GROUP(GRP_CNTRL)) u_bank_cntrl (
		.clk (clk), .rst_ (rst_), .sel_cmd (sel_cmd.dst), .sus_cmd (sus_cmd.dst),
		.sel (cntrl_e), .sus (), .any_on (any_on[5])
	);

	settle_timer #(.SETTLE_CYCLES(SETTLE_CYCLES)) u_settle (
		.clk    (clk),
		.rst_   (rst_),
		.any_on (any_on),
		.busy   (busy)
	);

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD  = 4,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst_
);

	initial
	begin
		clk  = 1'b0;
		rst_ = 1'b0;
	end

	always #HALF_PERIOD clk = ~clk;	// 8 ns period

	// release on a rising edge, after RESET_CYCLES edges with reset low
	initial
	begin
		repeat (RESET_CYCLES) @(posedge clk);
		rst_ <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== bench/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top import ctl_pkg::*; ();

	localparam int SEED   = 45;
	localparam int SETTLE = 25;
	localparam int N_RW   = 16;
	localparam int N_IMSH = 12;
	localparam int N_SEL  = 80;
	localparam int N_MIX  = 80;
	// reset, register loops, command writes, busy countdown, margin
	localparam int MAX_CYCLES = 20 + 6 * N_RW + 8 * N_IMSH + 3 * (N_SEL + N_MIX + 20)
		+ 3 * SETTLE + 200;

	logic                               clk;
	logic                               rst_;
	logic                               bus_valid;
	logic                               bus_wr;
	addr_t                              bus_addr;
	logic [DATA_WIDTH-1:0]              bus_wdata;
	logic [DATA_WIDTH-1:0]              bus_rdata;
	logic                               bus_rvalid;
	logic [BANK_WIDTH-1:0]              a_sel, b_sel, c_sel, a_sus, b_sus, c_sus;
	logic [BANK_WIDTH+D_HIGH_WIDTH-1:0] d_sel, d_sus;
	logic [CNTRL_WIDTH-1:0]             cntrl_e;
	logic                               co_en;
	logic [1:0]                         co_a, co_b, co_c, co_d;
	logic                               busy;

	logic [31:0]  m_sel [NUM_BANKS];	// reference relay state
	logic [31:0]  m_sus [NUM_BANKS];
	logic         m_en_1;
	logic         m_en_2;
	logic [7:0]   m_err;
	int           neg_count   = 0;
	int           cycle_count = 0;
	int           due_q [$];	// negedge at which a snapshot is due
	logic [383:0] snap_q [$];
	string        bank_name [NUM_BANKS] = '{"a", "b", "c", "d_low", "d_high", "cntrl"};

	tb_clock #(.RESET_CYCLES(10)) u_clock (.clk(clk), .rst_(rst_));

	relay_ctrl_top #(.SETTLE_CYCLES(SETTLE)) DUT (
		.clk (clk), .rst_ (rst_), .bus_valid (bus_valid), .bus_wr (bus_wr),
		.bus_addr (bus_addr), .bus_wdata (bus_wdata), .bus_rdata (bus_rdata),
		.bus_rvalid (bus_rvalid), .a_sel (a_sel), .b_sel (b_sel), .c_sel (c_sel),
		.d_sel (d_sel), .cntrl_e (cntrl_e), .a_sus (a_sus), .b_sus (b_sus),
		.c_sus (c_sus), .d_sus (d_sus), .co_en (co_en), .co_a (co_a), .co_b (co_b),
		.co_c (co_c), .co_d (co_d), .busy (busy)
	);

	function automatic logic [31:0] make_cmd(input logic [3:0] mode, input logic on,
		input logic [2:0] grp, input logic [4:0] idx, input logic en);
		return {15'd0, idx, en, grp, 3'd0, on, mode};
	endfunction

	function automatic logic [31:0] random_cmd(input logic en);
		return make_cmd(4'b0001 << ($urandom % 4), ($urandom % 3) != 0,
			3'($urandom % 6 + 1), 5'($urandom), en);
	endfunction

	function automatic int bank_width(input int b);
		return (b == 4) ? D_HIGH_WIDTH : (b == 5) ? CNTRL_WIDTH : BANK_WIDTH;
	endfunction

	// bits of bank b that a command reaches
	// bank b has group code b + 1
	function automatic logic [31:0] target_mask(input int b, input logic [31:0] cmd);
		logic [31:0] all_bits;
		logic [31:0] one_bit;
		int          idx;
		all_bits = (bank_width(b) == 32) ? 32'hFFFF_FFFF : (32'd1 << bank_width(b)) - 1;
		idx      = cmd[16:12];
		one_bit  = (idx < bank_width(b)) ? (32'd1 << idx) : 32'd0;
		case (cmd[3:0])
			4'b0001: return all_bits;
			4'b0010: return (cmd[10:8] == b + 1) ? all_bits : 32'd0;
			4'b0100: return (cmd[10:8] == b + 1) ? one_bit : 32'd0;
			4'b1000: return (b < 4) ? one_bit : 32'd0;	// no section for d-high or control
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic [383:0] snapshot();
		logic [383:0] s;
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			s[b*64 +: 32]      = m_sel[b];
			s[b*64 + 32 +: 32] = m_sus[b];
		end
		return s;
	endfunction

	function automatic logic [31:0] port_sel(input int b);
		case (b)
			0: return a_sel;
			1: return b_sel;
			2: return c_sel;
			3: return d_sel[31:0];
			4: return 32'(d_sel[55:32]);
			default: return 32'(cntrl_e);
		endcase
	endfunction

	function automatic logic [31:0] port_sus(input int b);
		case (b)
			0: return a_sus;
			1: return b_sus;
			2: return c_sus;
			3: return d_sus[31:0];
			4: return 32'(d_sus[55:32]);
			default: return 32'd0;	// control bank has no sus side
		endcase
	endfunction

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("ERROR at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic compare_ports(input logic [383:0] s);
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			check({bank_name[b], "_sel"}, port_sel(b), s[b*64 +: 32]);
			check({bank_name[b], "_sus"}, port_sus(b), s[b*64 + 32 +: 32]);
		end
	endtask

	task automatic apply_cmd(input bit to_sus, input logic [31:0] cmd);
		logic [31:0] m;
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			m = (to_sus && b == 5) ? 32'd0 : target_mask(b, cmd);
			if (!m_en_1 && !m_en_2)
			begin
				m_sel[b] = '0;	// both channels disabled
				m_sus[b] = '0;
			end
			else if (cmd[4])
			begin
				m_sel[b] = to_sus ? (m_sel[b] & ~m) : (m_sel[b] | m);
				m_sus[b] = to_sus ? (m_sus[b] | m) : (m_sus[b] & ~m);
			end
			else if (to_sus)
				m_sus[b] = m_sus[b] & ~m;
			else
				m_sel[b] = m_sel[b] & ~m;
		end
	endtask

	// called at the edge where the DUT accepts the access
	task automatic model_access(input logic [15:0] off, input bit wr, input logic [31:0] data);
		case (off)
			REG_IN_1, REG_IN_2:
				if (wr)
				begin
					if (off == REG_IN_1)
						m_en_1 = data[11];
					else
						m_en_2 = data[11];
					if (!$onehot(data[3:0]))
						m_err[7] = 1'b1;
					apply_cmd(off == REG_IN_2, data);
					due_q.push_back(neg_count + 3);	// two edges after the write edge
					snap_q.push_back(snapshot());
				end
			REG_R_ERR:
				if (!wr)
					m_err = '0;
			REG_C_IMSH, REG_R_TEST: ;
			default:
				m_err[0] = 1'b1;	// unmapped
		endcase
	endtask

	task automatic bus_write(input logic [15:0] off, input logic [31:0] data);
		@(posedge clk);
		bus_valid <= 1'b1;
		bus_wr    <= 1'b1;
		bus_addr  <= {off, 4'($urandom)};	// low nibble is not decoded
		bus_wdata <= data;
		@(posedge clk);
		bus_valid <= 1'b0;
		bus_wr    <= 1'b0;
		model_access(off, 1'b1, data);
	endtask

	task automatic bus_read(input logic [15:0] off, output logic [31:0] data);
		@(posedge clk);
		bus_valid <= 1'b1;
		bus_wr    <= 1'b0;
		bus_addr  <= {off, 4'($urandom)};
		@(negedge clk);
		check("bus_rvalid", bus_rvalid, 0);
		@(posedge clk);
		bus_valid <= 1'b0;
		model_access(off, 1'b0, 32'd0);
		@(negedge clk);
		check("bus_rvalid", bus_rvalid, 1);
		data = bus_rdata;
	endtask

	task automatic drain();
		while (due_q.size() != 0)
			@(negedge clk);
	endtask

	always @(negedge clk)
	begin
		neg_count = neg_count + 1;
		while (due_q.size() != 0 && due_q[0] == neg_count)
		begin
			void'(due_q.pop_front());
			compare_ports(snap_q.pop_front());
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		logic [31:0] d;
		logic [31:0] rd;
		logic [7:0]  exp_err;
		void'($urandom(SEED));
		bus_valid = 1'b0;
		bus_wr    = 1'b0;
		bus_addr  = '0;
		bus_wdata = '0;
		m_sel     = '{default: '0};
		m_sus     = '{default: '0};
		m_en_1    = 1'b0;
		m_en_2    = 1'b0;
		m_err     = '0;
		wait (rst_ === 1'b1);
		@(negedge clk);
		compare_ports('0);
		check("co_en", co_en, 1);
		check("busy", busy, 0);
		check("bus_rvalid", bus_rvalid, 0);

		repeat (N_RW)
		begin
			d = $urandom;
			bus_write(REG_R_TEST, d);
			bus_read(REG_R_TEST, rd);
			check("R_TEST readback", rd, d);
		end
		repeat (N_IMSH)
		begin
			d = $urandom % 512;
			bus_write(REG_C_IMSH, d);
			@(negedge clk);
			check("co_en", co_en, !d[8]);
			check("co_a", co_a, d[7:6]);
			check("co_b", co_b, d[5:4]);
			check("co_c", co_c, d[3:2]);
			check("co_d", co_d, d[1:0]);
			bus_read(REG_C_IMSH, rd);
			check("C_IMSH readback", rd, d);
		end

		// sel channel alone followed by out-of-range and control-enable addresses
		repeat (N_SEL)
			bus_write(REG_IN_1, random_cmd(1'b1));
		bus_write(REG_IN_1, make_cmd(MODE_ADDR, 1'b1, GRP_D_HIGH, 5'd26, 1'b1));
		bus_write(REG_IN_1, make_cmd(MODE_ADDR, 1'b1, GRP_CNTRL, 5'd2, 1'b1));
		bus_write(REG_IN_1, make_cmd(MODE_ADDR, 1'b1, GRP_CNTRL, 5'd9, 1'b1));
		drain();

		// both channels mixed
		bus_write(REG_IN_2, make_cmd(MODE_FULL, 1'b0, 3'd0, 5'd0, 1'b1));
		repeat (N_MIX)
		begin
			if ($urandom % 2)
				bus_write(REG_IN_1, random_cmd(1'b1));
			else
				bus_write(REG_IN_2, random_cmd(1'b1));
		end
		bus_write(REG_IN_1, make_cmd(MODE_ADDR, 1'b1, GRP_A, 5'd5, 1'b1));
		bus_write(REG_IN_2, make_cmd(MODE_ADDR, 1'b1, GRP_A, 5'd5, 1'b1));
		drain();
		check("a_sel[5]", a_sel[5], 0);
		check("a_sus[5]", a_sus[5], 1);
		bus_write(REG_IN_1, make_cmd(MODE_FULL, 1'b0, 3'd0, 5'd0, 1'b0));
		bus_write(REG_IN_2, make_cmd(MODE_FULL, 1'b1, 3'd0, 5'd0, 1'b0));
		drain();
		compare_ports('0);	// disabling both drops every relay

		// error register
		bus_write(REG_IN_1, make_cmd(4'b0011, 1'b1, GRP_A, 5'd0, 1'b1));
		bus_read(16'h1234, rd);
		check("unmapped readback", rd, 0);
		exp_err = m_err;
		bus_read(REG_R_ERR, rd);
		check("R_ERR", rd, {24'd0, exp_err});
		bus_read(REG_R_ERR, rd);
		check("R_ERR after clear", rd, 0);

		// busy settle countdown
		bus_write(REG_IN_2, make_cmd(MODE_FULL, 1'b0, 3'd0, 5'd0, 1'b0));
		bus_write(REG_IN_1, make_cmd(MODE_FULL, 1'b1, 3'd0, 5'd0, 1'b1));
		drain();
		check("busy", busy, 1);
		bus_read(REG_IN_1, rd);
		check("IN_1 readback", rd, make_cmd(MODE_FULL, 1'b1, 3'd0, 5'd0, 1'b1) | (1 << BUSY_BIT));
		bus_write(REG_IN_1, make_cmd(MODE_FULL, 1'b0, 3'd0, 5'd0, 1'b0));
		for (int k = 0; k < SETTLE; k++)
		begin
			@(negedge clk);	// relays open at the next edge
			check("busy", busy, 1);
		end
		bus_read(REG_IN_1, rd);	// accepted at the edge that ends the last busy cycle
		check("IN_1 readback", rd,
			make_cmd(MODE_FULL, 1'b0, 3'd0, 5'd0, 1'b0) | (1 << BUSY_BIT));
		check("busy", busy, 0);
		bus_read(REG_IN_1, rd);
		check("IN_1 readback", rd, make_cmd(MODE_FULL, 1'b0, 3'd0, 5'd0, 1'b0));
		drain();

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/ctl_pkg.sv
design/relay_cmd_if.sv
design/bus_regs.sv
design/relay_bank.sv
design/settle_timer.sv
design/relay_ctrl_top.sv
bench/tb_clock.sv
bench/tb_top.sv
